/* Makefile */
VERILATOR ?= verilator
TOP       ?= sweep_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* TEST FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG); then echo "no pass in log"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/sweep_asserts.sv */
module sweep_asserts (
  input logic             clk125,
  input logic             areset_n,
  input logic             result_valid,
  input logic             sweep_done,
  input sweep_pkg::addr_t point,
  input sweep_pkg::addr_t last_point
);

  // result strobe is a single cycle pulse
  result_one_cycle: assert property (
    @(posedge clk125) disable iff (!areset_n) result_valid |=> !result_valid
  ) else $error("result_valid stayed high for more than one cycle");

  // done only after the last result has gone
  done_apart: assert property (
    @(posedge clk125) disable iff (!areset_n) !(sweep_done && result_valid)
  ) else $error("sweep_done and result_valid high in the same cycle");

  // index stays inside the programmed sweep
  point_in_range: assert property (
    @(posedge clk125) disable iff (!areset_n) point <= last_point
  ) else $error("point index went past last_point");

endmodule

bind sweep_fsm sweep_asserts u_asserts (
  .clk125(clk125), .areset_n(areset_n), .result_valid(result_valid),
  .sweep_done(sweep_done), .point(point), .last_point(last_point)
);

/* dv/sweep_tb.sv */
module sweep_tb;
  import sweep_pkg::*;

  localparam int points = 5;
  localparam int sweeps = 2;
  localparam int settle_n = 4;
  localparam int meas_n = 4;
  localparam int min_run = 10;
  localparam int half_min = 16;
  localparam int half_max = 40;
  // every point of both sweeps at the longest period plus margin for reset and table load
  localparam int cycle_limit = sweeps * points * (settle_n + meas_n + 2) * 2 * half_max + 2000;

  logic    clk125 = 1'b0;
  logic    areset_n;
  logic    start;
  addr_t   last_point;
  logic    table_wr_en;
  addr_t   table_wr_addr;
  freq_t   table_wr_data;
  sample_t ref_sample;
  sample_t ch_a;
  sample_t ch_b;
  freq_t   freq_word;
  amp_t    amp_a;
  amp_t    amp_b;
  acc_t    phase_lag;
  logic    result_valid;
  addr_t   result_point;
  logic    sweep_done;

  // stimulus sets for every point of each sweep
  logic [31:0] lcg_state;
  freq_t       table_words [points];
  int          half_per [sweeps*points];
  int          amp_a_set [sweeps*points];
  int          amp_b_set [sweeps*points];
  int          delay_set [sweeps*points];
  logic        checking;
  int          results_seen;
  int          run_cycles;

  always #10 clk125 = ~clk125;

  sweep_top #(.SETTLE_CYCLES(settle_n), .MEAS_CYCLES(meas_n), .MIN_RUN(min_run)) DUT (
    .clk125(clk125), .areset_n(areset_n), .start(start), .last_point(last_point),
    .table_wr_en(table_wr_en), .table_wr_addr(table_wr_addr), .table_wr_data(table_wr_data),
    .ref_sample(ref_sample), .ch_a(ch_a), .ch_b(ch_b), .freq_word(freq_word),
    .amp_a(amp_a), .amp_b(amp_b), .phase_lag(phase_lag), .result_valid(result_valid),
    .result_point(result_point), .sweep_done(sweep_done)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // uniform pick in lo..hi from the upper lcg bits
  function automatic int draw_range(input int lo, input int hi);
    lcg_state = lcg_step(lcg_state);
    return lo + int'((lcg_state >> 16) % (hi - lo + 1));
  endfunction

  // level of a square wave that starts high
  function automatic int square_level(input int t, input int half, input int amp);
    if ((t % (2 * half)) < half)
      return amp;
    return -amp;
  endfunction

  // expected result of one point from the driven waveforms
  function automatic void expected_result(input int idx, output logic [31:0] e_amp_a,
      output logic [31:0] e_amp_b, output logic [31:0] e_lag, output logic [31:0] e_freq);
    int a_pp;
    int b_pp;
    // half the peak to peak of a +-amp square wave
    a_pp = amp_a_set[idx] - (-amp_a_set[idx]);
    b_pp = amp_b_set[idx] - (-amp_b_set[idx]);
    e_amp_a = 32'(a_pp / 2);
    e_amp_b = 32'(b_pp / 2);
    // equal detector latency on a and b so the lag is the b delay in samples
    e_lag = 32'(delay_set[idx]);
    e_freq = table_words[idx % points];
  endfunction

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic require_true(input logic cond, input string what);
    assert (cond === 1'b1)
    else
    begin
      $display("ERROR %s", what);
      abort_run();
    end
  endtask

  task automatic generate_stimulus();
    int i;
    for (i = 0; i < points; i++)
    begin
      lcg_state = lcg_step(lcg_state);
      table_words[i] = lcg_state;
    end
    for (i = 0; i < sweeps * points; i++)
    begin
      half_per[i]  = draw_range(half_min, half_max);
      amp_a_set[i] = draw_range(100, 8000);
      amp_b_set[i] = draw_range(100, 8000);
      delay_set[i] = draw_range(0, half_per[i] - 1);
    end
    // one point with coincident crossings
    delay_set[2] = 0;
  endtask

  task automatic load_table();
    int i;
    for (i = 0; i < points; i++)
    begin
      @(negedge clk125);
      table_wr_en   = 1'b1;
      table_wr_addr = addr_t'(i);
      table_wr_data = table_words[i];
    end
    @(negedge clk125);
    table_wr_en = 1'b0;
  endtask

  // ref and a in phase and b delayed by the point's lag
  // next set once a result is out
  initial
  begin : wave_gen
    int t;
    int idx;
    int b_level;
    ref_sample = '0;
    ch_a = '0;
    ch_b = '0;
    t = 0;
    idx = 0;
    forever
    begin
      @(negedge clk125);
      if (result_valid === 1'b1 && idx < sweeps * points - 1)
      begin
        idx = idx + 1;
        t = 0;
      end
      if (t >= delay_set[idx])
        b_level = square_level(t - delay_set[idx], half_per[idx], amp_b_set[idx]);
      else
        b_level = -amp_b_set[idx];
      ref_sample = sample_t'(square_level(t, half_per[idx], amp_a_set[idx]));
      ch_a = sample_t'(square_level(t, half_per[idx], amp_a_set[idx]));
      ch_b = sample_t'(b_level);
      t = t + 1;
    end
  end

  initial
  begin : compare
    logic [31:0] e_amp_a;
    logic [31:0] e_amp_b;
    logic [31:0] e_lag;
    logic [31:0] e_freq;
    int          exp_idx;
    logic        last_seen;
    logic        done_seen;
    exp_idx = 0;
    last_seen = 1'b0;
    done_seen = 1'b0;
    results_seen = 0;
    wait (checking === 1'b1);
    forever
    begin
      @(negedge clk125);
      if (result_valid === 1'b1)
      begin
        expected_result(exp_idx, e_amp_a, e_amp_b, e_lag, e_freq);
        compare_value($sformatf("result_point %0d", exp_idx), 32'(exp_idx % points),
          32'(result_point));
        compare_value($sformatf("amp_a %0d", exp_idx), e_amp_a, amp_a);
        compare_value($sformatf("amp_b %0d", exp_idx), e_amp_b, amp_b);
        compare_value($sformatf("phase_lag %0d", exp_idx), e_lag, phase_lag);
        if (result_point == last_point)
          last_seen = 1'b1;
        exp_idx = exp_idx + 1;
        results_seen = results_seen + 1;
      end
      // fsm index parks on the last point until sweep_done falls
      if (last_seen && sweep_done === 1'b1)
        done_seen = 1'b1;
      else if (done_seen && sweep_done === 1'b0)
      begin
        last_seen = 1'b0;
        done_seen = 1'b0;
      end
      if (!last_seen)
      begin
        expected_result(exp_idx % (sweeps * points), e_amp_a, e_amp_b, e_lag, e_freq);
        compare_value($sformatf("freq_word point %0d", exp_idx % points), e_freq, freq_word);
      end
    end
  end

  initial
  begin : watchdog
    run_cycles = 0;
    forever
    begin
      @(posedge clk125);
      run_cycles = run_cycles + 1;
      if (run_cycles >= cycle_limit)
      begin
        $display("timeout, sweep not finished within %0d cycles", cycle_limit);
        abort_run();
      end
    end
  end

  initial
  begin : main
    int s;
    checking = 1'b0;
    areset_n = 1'b0;
    start = 1'b0;
    last_point = addr_t'(points - 1);
    table_wr_en = 1'b0;
    table_wr_addr = '0;
    table_wr_data = '0;
    lcg_state = 32'd11;
    generate_stimulus();
    repeat (3) @(posedge clk125);
    @(negedge clk125);
    areset_n = 1'b1;
    @(negedge clk125);
    require_true(!result_valid && !sweep_done, "result_valid or sweep_done high after reset");
    load_table();
    checking = 1'b1;
    for (s = 0; s < sweeps; s++)
    begin
      start = 1'b1;
      @(negedge clk125);
      while (sweep_done !== 1'b1)
        @(negedge clk125);
      compare_value($sformatf("results after sweep %0d", s), 32'((s + 1) * points),
        32'(results_seen));
      // done holds while start stays high
      repeat (8)
      begin
        @(negedge clk125);
        require_true(sweep_done, "sweep_done dropped while start was still high");
      end
      start = 1'b0;
      @(negedge clk125);
      require_true(!sweep_done, "sweep_done still high one cycle after start went low");
      repeat (2) @(negedge clk125);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* src.f */
src/sweep_pkg.sv
src/freq_table.sv
src/crossing_detect.sv
src/cycle_counter.sv
src/peak_tracker.sv
src/phase_meter.sv
src/sweep_fsm.sv
src/sweep_top.sv
dv/sweep_asserts.sv
dv/sweep_tb.sv

/* src/crossing_detect.sv */
module crossing_detect #(
  parameter int MIN_RUN = sweep_pkg::default_min_run
) (
  input  logic               clk125,
  input  logic               areset_n,
  input  sweep_pkg::sample_t sample,
  output sweep_pkg::sample_t sample_q,
  output logic               crossing
);
  import sweep_pkg::*;

  // wait for non-negative, count the run, armed for the drop
  typedef enum logic [1:0] {
    wait_pos,
    run,
    armed
  } run_state_t;

  localparam count_t run_limit = count_t'(MIN_RUN);

  run_state_t run_state;
  count_t     run_cnt;
  logic       is_neg;

  // sign bit of the registered sample
  assign is_neg = sample_q[sample_w-1];

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      sample_q  <= '0;
      run_state <= wait_pos;
      run_cnt   <= '0;
      crossing  <= 1'b0;
    end
    else
    begin
      sample_q <= sample;
      // single cycle pulse
      crossing <= 1'b0;
      case (run_state)
        wait_pos:
          if (!is_neg)
          begin
            run_state <= run;
            run_cnt   <= count_t'(1);
          end
        run:
          if (is_neg)
          begin
            // chatter near zero, start over
            run_state <= wait_pos;
            run_cnt   <= '0;
          end
          else if (run_cnt < run_limit)
            run_cnt <= run_cnt + 1'b1;
          else
          begin
            // run longer than MIN_RUN
            run_state <= armed;
            run_cnt   <= '0;
          end
        armed:
          if (is_neg)
          begin
            run_state <= wait_pos;
            crossing  <= 1'b1;
          end
        default:
          run_state <= wait_pos;
      endcase
    end
  end

endmodule

/* src/cycle_counter.sv */
module cycle_counter #(
  parameter int SETTLE_CYCLES = sweep_pkg::default_settle_cycles,
  parameter int MEAS_CYCLES   = sweep_pkg::default_meas_cycles
) (
  input  logic                    clk125,
  input  logic                    areset_n,
  input  sweep_pkg::sweep_state_t state,
  input  logic                    ref_cross,
  input  logic                    a_cross,
  input  logic                    b_cross,
  output logic                    settle_end,
  output logic                    meas_end
);
  import sweep_pkg::*;

  localparam count_t settle_last = count_t'(SETTLE_CYCLES - 1);
  localparam count_t meas_last   = count_t'(MEAS_CYCLES - 1);
  localparam count_t meas_full   = count_t'(MEAS_CYCLES);

  sweep_state_t state_q;
  count_t       cross_cnt;
  logic         a_done;

  // enough a crossings seen, this cycle's one included
  assign a_done = (cross_cnt >= meas_full) || (a_cross && (cross_cnt == meas_last));

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state_q    <= idle;
      cross_cnt  <= '0;
      settle_end <= 1'b0;
      meas_end   <= 1'b0;
    end
    else
    begin
      state_q    <= state;
      settle_end <= 1'b0;
      meas_end   <= 1'b0;
      // fresh count on every state change
      if (state != state_q)
        cross_cnt <= '0;
      else
      begin
        case (state)
          settle:
            if (ref_cross)
            begin
              cross_cnt <= cross_cnt + 1'b1;
              if (cross_cnt == settle_last)
                settle_end <= 1'b1;
            end
          measure:
          begin
            // saturate once the a count is reached
            if (a_cross && (cross_cnt < meas_full))
              cross_cnt <= cross_cnt + 1'b1;
            // close on the b crossing that follows
            if (b_cross && a_done)
              meas_end <= 1'b1;
          end
          default:
            cross_cnt <= '0;
        endcase
      end
    end
  end

endmodule

/* src/freq_table.sv */
module freq_table (
  input  logic             clk125,
  input  logic             table_wr_en,
  input  sweep_pkg::addr_t table_wr_addr,
  input  sweep_pkg::freq_t table_wr_data,
  input  sweep_pkg::addr_t point,
  output sweep_pkg::freq_t freq_word
);
  import sweep_pkg::*;

  // one word per addressable point
  localparam int depth = 2 ** addr_w;

  // frequency words, loaded by the host before a sweep
  freq_t mem [depth];

  // host write port, no handshake
  always_ff @(posedge clk125)
  begin
    if (table_wr_en)
    begin
      mem[table_wr_addr] <= table_wr_data;
    end
  end

  // current point word straight out, no read latency
  // so the source sees the new word as soon as the index moves
  assign freq_word = mem[point];

endmodule

/* src/peak_tracker.sv */
module peak_tracker (
  input  logic                    clk125,
  input  logic                    areset_n,
  input  sweep_pkg::sweep_state_t state,
  input  sweep_pkg::sample_t      sample_q,
  output sweep_pkg::amp_t         amplitude
);
  import sweep_pkg::*;

  amp_t pk_max;
  amp_t pk_min;
  amp_t sample_ext;

  // sign extend to result width
  assign sample_ext = amp_t'(sample_q);

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      pk_max    <= '0;
      pk_min    <= '0;
      amplitude <= '0;
    end
    else
    begin
      case (state)
        measure:
        begin
          if (sample_ext > pk_max)
            pk_max <= sample_ext;
          if (sample_ext < pk_min)
            pk_min <= sample_ext;
        end
        // half of peak to peak, held until next report
        report:
          amplitude <= (pk_max - pk_min) >>> 1;
        default:
        begin
          // both peaks restart from zero before measure
          pk_max <= '0;
          pk_min <= '0;
        end
      endcase
    end
  end

endmodule

/* src/phase_meter.sv */
module phase_meter (
  input  logic                    clk125,
  input  logic                    areset_n,
  input  sweep_pkg::sweep_state_t state,
  input  logic                    a_cross,
  input  logic                    b_cross,
  output sweep_pkg::acc_t         phase_lag
);
  import sweep_pkg::*;

  // samples since the last a crossing
  acc_t lag_cnt;
  // last a to b distance
  acc_t lag_cap;
  // an a crossing seen in this measure
  logic seen_a;

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      lag_cnt   <= '0;
      lag_cap   <= '0;
      seen_a    <= 1'b0;
      phase_lag <= '0;
    end
    else
    begin
      case (state)
        measure:
        begin
          // restart at each a crossing
          if (a_cross)
          begin
            lag_cnt <= acc_t'(1);
            seen_a  <= 1'b1;
          end
          else
            lag_cnt <= lag_cnt + 1'b1;
          // same cycle crossings mean zero lag
          if (b_cross && a_cross)
            lag_cap <= '0;
          else if (b_cross && seen_a)
            lag_cap <= lag_cnt;
        end
        report:
          phase_lag <= lag_cap;
        default:
        begin
          lag_cnt <= '0;
          lag_cap <= '0;
          seen_a  <= 1'b0;
        end
      endcase
    end
  end

endmodule

/* src/sweep_fsm.sv */
module sweep_fsm (
  input  logic                    clk125,
  input  logic                    areset_n,
  input  logic                    start,
  input  sweep_pkg::addr_t        last_point,
  input  logic                    settle_end,
  input  logic                    meas_end,
  output sweep_pkg::sweep_state_t state,
  output sweep_pkg::addr_t        point,
  output logic                    result_valid,
  output sweep_pkg::addr_t        result_point,
  output logic                    sweep_done
);
  import sweep_pkg::*;

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state        <= idle;
      point        <= '0;
      result_valid <= 1'b0;
      result_point <= '0;
      sweep_done   <= 1'b0;
    end
    else
    begin
      // strobe, one cycle after report
      result_valid <= 1'b0;
      case (state)
        idle:
        begin
          sweep_done <= 1'b0;
          if (start)
          begin
            state <= settle;
            point <= '0;
          end
        end
        // wait for the reference to settle on the new word
        settle:
          if (settle_end)
            state <= measure;
        measure:
          if (meas_end)
            state <= report;
        // trackers latch here
        report:
        begin
          result_valid <= 1'b1;
          result_point <= point;
          if (point == last_point)
            state <= done;
          else
          begin
            point <= point + 1'b1;
            state <= settle;
          end
        end
        done:
        begin
          // registered so it trails the last result_valid
          sweep_done <= 1'b1;
          if (!start)
          begin
            // handshake with host, start low ends the sweep
            state      <= idle;
            point      <= '0;
            sweep_done <= 1'b0;
          end
        end
        default:
          state <= idle;
      endcase
    end
  end

endmodule

/* src/sweep_pkg.sv */
package sweep_pkg;

  // signed adc and reference sample width
  localparam int sample_w = 14;
  // amplitude and phase result width
  localparam int acc_w = 32;
  // frequency word sent to the external sine source
  localparam int freq_w = 32;
  // table depth and point index
  localparam int addr_w = 8;
  // run-length and crossing counters
  localparam int count_w = 16;

  // defaults for the top level parameters
  localparam int default_settle_cycles = 4;
  localparam int default_meas_cycles = 4;
  localparam int default_min_run = 10;

  typedef logic signed [sample_w-1:0] sample_t;
  // amplitude, signed
  typedef logic signed [acc_w-1:0] amp_t;
  // phase lag in samples, unsigned
  typedef logic [acc_w-1:0] acc_t;
  typedef logic [freq_w-1:0] freq_t;
  typedef logic [addr_w-1:0] addr_t;
  typedef logic [count_w-1:0] count_t;

  // one settle/measure/report pass per sweep point
  typedef enum logic [2:0] {
    idle,
    settle,
    measure,
    report,
    done
  } sweep_state_t;

endpackage

/* src/sweep_top.sv */
module sweep_top #(
  parameter int SETTLE_CYCLES = sweep_pkg::default_settle_cycles,
  parameter int MEAS_CYCLES   = sweep_pkg::default_meas_cycles,
  parameter int MIN_RUN       = sweep_pkg::default_min_run
) (
  input  logic               clk125,
  input  logic               areset_n,
  input  logic               start,
  input  sweep_pkg::addr_t   last_point,
  input  logic               table_wr_en,
  input  sweep_pkg::addr_t   table_wr_addr,
  input  sweep_pkg::freq_t   table_wr_data,
  input  sweep_pkg::sample_t ref_sample,
  input  sweep_pkg::sample_t ch_a,
  input  sweep_pkg::sample_t ch_b,
  output sweep_pkg::freq_t   freq_word,
  output sweep_pkg::amp_t    amp_a,
  output sweep_pkg::amp_t    amp_b,
  output sweep_pkg::acc_t    phase_lag,
  output logic               result_valid,
  output sweep_pkg::addr_t   result_point,
  output logic               sweep_done
);
  import sweep_pkg::*;

  sweep_state_t state;
  addr_t        point;
  sample_t      a_q;
  sample_t      b_q;
  logic         ref_cross;
  logic         a_cross;
  logic         b_cross;
  logic         settle_end;
  logic         meas_end;

  freq_table u_table (
    .clk125(clk125), .table_wr_en(table_wr_en), .table_wr_addr(table_wr_addr),
    .table_wr_data(table_wr_data), .point(point), .freq_word(freq_word)
  );

  // reference only feeds the settle count, its sample is not tracked
  crossing_detect #(.MIN_RUN(MIN_RUN)) u_ref_det (
    .clk125(clk125), .areset_n(areset_n), .sample(ref_sample),
    .sample_q(), .crossing(ref_cross)
  );

  crossing_detect #(.MIN_RUN(MIN_RUN)) u_a_det (
    .clk125(clk125), .areset_n(areset_n), .sample(ch_a), .sample_q(a_q), .crossing(a_cross)
  );

  crossing_detect #(.MIN_RUN(MIN_RUN)) u_b_det (
    .clk125(clk125), .areset_n(areset_n), .sample(ch_b), .sample_q(b_q), .crossing(b_cross)
  );

  cycle_counter #(.SETTLE_CYCLES(SETTLE_CYCLES), .MEAS_CYCLES(MEAS_CYCLES)) u_cycles (
    .clk125(clk125), .areset_n(areset_n), .state(state), .ref_cross(ref_cross),
    .a_cross(a_cross), .b_cross(b_cross), .settle_end(settle_end), .meas_end(meas_end)
  );

  peak_tracker u_peak_a (
    .clk125(clk125), .areset_n(areset_n), .state(state), .sample_q(a_q), .amplitude(amp_a)
  );

  peak_tracker u_peak_b (
    .clk125(clk125), .areset_n(areset_n), .state(state), .sample_q(b_q), .amplitude(amp_b)
  );

  phase_meter u_phase (
    .clk125(clk125), .areset_n(areset_n), .state(state), .a_cross(a_cross),
    .b_cross(b_cross), .phase_lag(phase_lag)
  );

  sweep_fsm u_fsm (
    .clk125(clk125), .areset_n(areset_n), .start(start), .last_point(last_point),
    .settle_end(settle_end), .meas_end(meas_end), .state(state), .point(point),
    .result_valid(result_valid), .result_point(result_point), .sweep_done(sweep_done)
  );

endmodule
